//--- flist.f
logic/i2c_mon_pkg.sv
logic/i2c_line_sampler.sv
logic/i2c_byte_shifter.sv
logic/i2c_mon_ctrl.sv
logic/i2c_record_fifo.sv
logic/i2c_bus_monitor.sv
tests/i2c_bus_monitor_tb.sv

//--- Bender.yml
package:
  name: i2c_bus_monitor

sources:
  - logic/i2c_mon_pkg.sv
  - logic/i2c_line_sampler.sv
  - logic/i2c_byte_shifter.sv
  - logic/i2c_mon_ctrl.sv
  - logic/i2c_record_fifo.sv
  - logic/i2c_bus_monitor.sv
  - target: test
    files:
      - tests/i2c_bus_monitor_tb.sv

//--- tests/i2c_bus_monitor_tb.sv
// drives ideal open-drain levels at 16 clocks per bit; partial slots stay within 1 to 7 bits
`timescale 1ns/100ps
`default_nettype none

module i2c_bus_monitor_tb
    import i2c_mon_pkg::*;
();

    localparam logic [31:0] SEED = 32'h5925_1614;
    // 12 plain, 8 restart, 7 truncated, 4 back-pressure, 1 overflow, 1 disabled
    localparam int unsigned N_TXN = 33;
    localparam int unsigned MAX_SLOTS = 6;
    // frames x slots x bits x clocks per bit, doubled
    localparam int unsigned TIMEOUT_CYCLES = N_TXN * MAX_SLOTS * SLOT_BITS * 16 * 2;

    // one bus transaction as the line tasks play it
    typedef struct packed {
        logic [7:0]      addr_byte;
        logic [3:0][7:0] data;
        logic [2:0]      n_data;
        // bit 0 for the address slot, then one per data byte
        logic [4:0]      acks;
        logic            restart;
        logic            no_stop;
        // bits of a partial slot before the STOP, 0 for none
        logic [3:0]      trunc;
        logic            monitor_on;
    } txn_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        enable_monitor;
    logic        sda;
    logic        scl;
    logic        rec_ready = 1'b0;
    logic        bus_busy;
    logic        rec_valid;
    mon_rec_t    rec;
    logic        overflow;
    logic        ready_en = 1'b0;
    logic [31:0] ready_state = SEED;
    logic [31:0] stim_state = SEED;
    int unsigned cycles = 0;
    mon_rec_t    exp_q[$];
    mon_state_t  ref_state = MON_IDLE;
    string       test_name = "reset";

    always #2 clk = ~clk;

    i2c_bus_monitor i_i2c_bus_monitor (
        .clk            (clk),
        .rst_n          (rst_n),
        .enable_monitor (enable_monitor),
        .sda            (sda),
        .scl            (scl),
        .bus_busy       (bus_busy),
        .rec_valid      (rec_valid),
        .rec            (rec),
        .rec_ready      (rec_ready),
        .overflow       (overflow)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic compare_values(input string name, input logic [15:0] exp_val,
                                  input logic [15:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp_val, act_val));
        end
    endtask

    function automatic txn_t make_txn(input int n);
        txn_t        t;
        logic [31:0] r;
        t = '0;
        r = stim_rand();
        t.addr_byte  = r[7:0];
        t.acks       = r[12:8];
        t.data       = stim_rand();
        t.n_data     = 3'(n);
        t.monitor_on = 1'b1;
        return t;
    endfunction

    // reference model, walks the control phases and queues the records a frame yields
    function automatic void expect_records(input txn_t t);
        mon_rec_t r;
        if (!t.monitor_on) begin
            ref_state = MON_IDLE;
        end else begin
            // START inside a frame means repeated START
            r = '{kind: REC_ADDR, byte_val: t.addr_byte, ack: t.acks[0],
                  restart: (ref_state != MON_IDLE), err: 1'b0};
            ref_state = MON_ADDR;
            exp_q.push_back(r);
            ref_state = MON_DATA;
            for (int i = 0; i < int'(t.n_data); i++) begin
                r = '{kind: REC_DATA, byte_val: t.data[i], ack: t.acks[i+1],
                      restart: 1'b0, err: 1'b0};
                exp_q.push_back(r);
            end
            if (!t.no_stop) begin
                // a partial slot only shows up as err on the STOP
                r = '{kind: REC_STOP, byte_val: 8'h00, ack: 1'b0,
                      restart: 1'b0, err: (t.trunc != 0)};
                exp_q.push_back(r);
                ref_state = MON_IDLE;
            end
        end
    endfunction

    // expects an idle bus, both lines high
    task automatic bus_start();
        sda = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic repeated_start();
        scl = 1'b0;
        repeat (4) @(negedge clk);
        sda = 1'b1;
        repeat (4) @(negedge clk);
        scl = 1'b1;
        repeat (8) @(negedge clk);
        sda = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    task automatic bus_stop();
        scl = 1'b0;
        repeat (4) @(negedge clk);
        sda = 1'b0;
        repeat (4) @(negedge clk);
        scl = 1'b1;
        repeat (8) @(negedge clk);
        sda = 1'b1;
        repeat (8) @(negedge clk);
    endtask

    // SDA changes only in the middle of the low phase
    task automatic clock_bit(input logic b);
        scl = 1'b0;
        repeat (4) @(negedge clk);
        sda = b;
        repeat (4) @(negedge clk);
        scl = 1'b1;
        repeat (8) @(negedge clk);
    endtask

    task automatic send_bits(input logic [7:0] b, input int n);
        for (int i = 0; i < n; i++) begin
            clock_bit(b[7-i]);
        end
    endtask

    task automatic send_slot(input logic [7:0] b, input logic ack);
        send_bits(b, 8);
        clock_bit(~ack);
    endtask

    task automatic run_frame(input txn_t t);
        logic [31:0] part;
        part = stim_rand();
        expect_records(t);
        if (t.restart) begin
            repeated_start();
        end else begin
            bus_start();
        end
        compare_values($sformatf("%s bus_busy", test_name), 16'(t.monitor_on), 16'(bus_busy));
        send_slot(t.addr_byte, t.acks[0]);
        for (int i = 0; i < int'(t.n_data); i++) begin
            send_slot(t.data[i], t.acks[i+1]);
        end
        if (t.trunc != 0) begin
            send_bits(part[7:0], int'(t.trunc));
        end
        if (!t.no_stop) begin
            compare_values($sformatf("%s bus_busy", test_name), 16'(t.monitor_on),
                           16'(bus_busy));
            bus_stop();
            compare_values($sformatf("%s bus_busy", test_name), 16'h0, 16'(bus_busy));
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ready for the next rising edge is picked first, so valid and ready
    // both high here means a transfer on that edge
    always @(negedge clk) begin
        mon_rec_t exp_rec;
        ready_state = xorshift32(ready_state);
        rec_ready = ready_en & ready_state[0];
        if (rst_n && rec_valid && rec_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("ERROR: the monitor delivered a record that was not expected");
            end else begin
                exp_rec = exp_q.pop_front();
                compare_values(test_name, 16'(exp_rec), 16'(rec));
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        txn_t t;
        rst_n = 1'b0;
        enable_monitor = 1'b0;
        sda = 1'b1;
        scl = 1'b1;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        enable_monitor = 1'b1;
        ready_en = 1'b1;
        repeat (4) @(negedge clk);

        test_name = "addr_data";
        for (int k = 0; k < 12; k++) begin
            run_frame(make_txn(int'(stim_rand() % 4)));
        end
        wait_drained();

        test_name = "restart";
        for (int k = 0; k < 4; k++) begin
            t = make_txn(int'(stim_rand() % 3));
            t.no_stop = 1'b1;
            run_frame(t);
            t = make_txn(int'(stim_rand() % 3));
            t.restart = 1'b1;
            run_frame(t);
        end

        test_name = "truncated";
        for (int k = 0; k < 7; k++) begin
            t = make_txn(int'(stim_rand() % 3));
            t.trunc = 4'(k + 1);
            run_frame(t);
        end

        // long frames back to back, ready still random
        test_name = "back_pressure";
        for (int k = 0; k < 4; k++) begin
            run_frame(make_txn(3));
        end
        wait_drained();
        compare_values("back_pressure overflow", 16'h0, 16'(overflow));

        test_name = "overflow";
        ready_en = 1'b0;
        repeat (4) @(negedge clk);
        run_frame(make_txn(4));
        // only the first records fit while nothing is taken out
        while (exp_q.size() > REC_FIFO_DEPTH) begin
            void'(exp_q.pop_back());
        end
        compare_values("overflow flag", 16'h1, 16'(overflow));
        enable_monitor = 1'b0;
        repeat (2) @(negedge clk);
        compare_values("overflow cleared", 16'h0, 16'(overflow));
        compare_values("overflow kept", 16'h1, 16'(rec_valid));
        enable_monitor = 1'b1;
        ready_en = 1'b1;
        wait_drained();

        test_name = "disabled";
        enable_monitor = 1'b0;
        t = make_txn(2);
        t.monitor_on = 1'b0;
        run_frame(t);
        repeat (20) @(negedge clk);
        enable_monitor = 1'b1;

        test_name = "final";
        wait_drained();
        repeat (20) @(negedge clk);
        if (exp_q.size() != 0 || rec_valid) begin
            abort_run("ERROR: records were left over at the end of the run");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_bus_monitor.sv
// passive monitor, never drives SDA or SCL; 7-bit addressing only, no stretching or timing checks
`timescale 1ns/100ps
`default_nettype none

module i2c_bus_monitor
    import i2c_mon_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable_monitor,
    input  logic     sda,
    input  logic     scl,
    output logic     bus_busy,
    output logic     rec_valid,
    output mon_rec_t rec,
    input  logic     rec_ready,
    output logic     overflow
);

    logic       sda_s;
    logic       start_evt;
    logic       stop_evt;
    logic       scl_rise;
    logic       slot_done;
    logic [7:0] slot_byte;
    logic       slot_ack;
    logic       mid_slot;
    logic       push;
    mon_rec_t   push_rec;

    i2c_line_sampler i_i2c_line_sampler (
        .clk       (clk),
        .rst_n     (rst_n),
        .sda       (sda),
        .scl       (scl),
        .sda_s     (sda_s),
        .start_evt (start_evt),
        .stop_evt  (stop_evt),
        .scl_rise  (scl_rise)
    );

    i2c_byte_shifter i_i2c_byte_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_busy  (bus_busy),
        .start_evt (start_evt),
        .scl_rise  (scl_rise),
        .sda_s     (sda_s),
        .slot_done (slot_done),
        .slot_byte (slot_byte),
        .slot_ack  (slot_ack),
        .mid_slot  (mid_slot)
    );

    i2c_mon_ctrl i_i2c_mon_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .enable_monitor (enable_monitor),
        .start_evt      (start_evt),
        .stop_evt       (stop_evt),
        .slot_done      (slot_done),
        .slot_byte      (slot_byte),
        .slot_ack       (slot_ack),
        .mid_slot       (mid_slot),
        .bus_busy       (bus_busy),
        .push           (push),
        .push_rec       (push_rec)
    );

    i2c_record_fifo i_i2c_record_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .enable_monitor (enable_monitor),
        .push           (push),
        .push_rec       (push_rec),
        .rec_valid      (rec_valid),
        .rec            (rec),
        .rec_ready      (rec_ready),
        .overflow       (overflow)
    );

endmodule

`default_nettype wire

//--- logic/i2c_record_fifo.sv
// drops pushes when full and flags overflow until the monitor is disabled; records survive disable
`timescale 1ns/100ps
`default_nettype none

module i2c_record_fifo
    import i2c_mon_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable_monitor,
    input  logic     push,
    input  mon_rec_t push_rec,
    output logic     rec_valid,
    output mon_rec_t rec,
    input  logic     rec_ready,
    output logic     overflow
);

    mon_rec_t             mem_q [REC_FIFO_DEPTH];
    logic [REC_PTR_W-1:0] wr_ptr;
    logic [REC_PTR_W-1:0] rd_ptr;
    logic [REC_CNT_W-1:0] count;
    logic                 pop;
    logic                 full;
    logic                 wr_en;

    assign rec_valid = (count != '0);
    assign full      = (count == REC_CNT_W'(REC_FIFO_DEPTH));
    assign pop       = rec_valid && rec_ready;
    // a pop frees the slot in the same cycle
    assign wr_en     = push && (!full || pop);
    assign rec       = mem_q[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == REC_PTR_W'(REC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == REC_PTR_W'(REC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + REC_CNT_W'(wr_en) - REC_CNT_W'(pop);
            // sticky until the monitor is switched off
            if (!enable_monitor) begin
                overflow <= 1'b0;
            end else if (push && !wr_en) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_ptr] <= push_rec;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_mon_ctrl.sv
// one record per slot or STOP, never stalls; a STOP seen while idle is ignored
`timescale 1ns/100ps
`default_nettype none

module i2c_mon_ctrl
    import i2c_mon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable_monitor,
    input  logic       start_evt,
    input  logic       stop_evt,
    input  logic       slot_done,
    input  logic [7:0] slot_byte,
    input  logic       slot_ack,
    input  logic       mid_slot,
    output logic       bus_busy,
    output logic       push,
    output mon_rec_t   push_rec
);

    mon_state_t state_q;
    mon_state_t state_d;
    logic       restart_q;
    logic       restart_d;
    logic       push_d;
    mon_rec_t   rec_d;

    assign bus_busy = (state_q != MON_IDLE);

    always_comb begin
        state_d   = state_q;
        restart_d = restart_q;
        push_d    = 1'b0;
        rec_d     = '{kind: REC_DATA, byte_val: slot_byte, ack: slot_ack,
                      restart: 1'b0, err: 1'b0};

        if (!enable_monitor) begin
            state_d   = MON_IDLE;
            restart_d = 1'b0;
        end else if (start_evt) begin
            // a START inside a frame is a repeated START
            state_d   = MON_ADDR;
            restart_d = (state_q != MON_IDLE);
        end else if (stop_evt) begin
            if (state_q != MON_IDLE) begin
                push_d = 1'b1;
                rec_d  = '{kind: REC_STOP, byte_val: 8'h00, ack: 1'b0,
                           restart: 1'b0, err: mid_slot};
            end
            state_d   = MON_IDLE;
            restart_d = 1'b0;
        end else if (slot_done) begin
            case (state_q)
                MON_ADDR: begin
                    push_d        = 1'b1;
                    rec_d.kind    = REC_ADDR;
                    rec_d.restart = restart_q;
                    state_d       = MON_DATA;
                end
                MON_DATA: begin
                    push_d = 1'b1;
                end
                MON_IDLE: begin
                    state_d = MON_IDLE;
                end
                default: begin
                    state_d = MON_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= MON_IDLE;
            restart_q <= 1'b0;
            push      <= 1'b0;
        end else begin
            state_q   <= state_d;
            restart_q <= restart_d;
            push      <= push_d;
        end
    end

    // record payload, only meaningful with push
    always_ff @(posedge clk) begin
        if (push_d) begin
            push_rec <= rec_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_byte_shifter.sv
// counts SCL rises only while the bus is busy; a STOP right after 8 bits completes that slot
`timescale 1ns/100ps
`default_nettype none

module i2c_byte_shifter
    import i2c_mon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       bus_busy,
    input  logic       start_evt,
    input  logic       scl_rise,
    input  logic       sda_s,
    output logic       slot_done,
    output logic [7:0] slot_byte,
    output logic       slot_ack,
    output logic       mid_slot
);

    logic [SLOT_CNT_W-1:0] bit_cnt;
    logic [7:0]            shift_q;
    logic                  last_bit;

    // ninth rise of the current slot
    assign last_bit = scl_rise && (bit_cnt == SLOT_CNT_W'(SLOT_BITS - 1));

    // every STOP is preceded by one SCL rise that carries no data bit,
    // so the slot only counts as partial past that rise
    assign mid_slot = (bit_cnt > SLOT_CNT_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            slot_done <= 1'b0;
        end else begin
            slot_done <= 1'b0;
            if (start_evt || !bus_busy) begin
                bit_cnt <= '0;
            end else if (last_bit) begin
                bit_cnt   <= '0;
                slot_done <= 1'b1;
            end else if (scl_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // data path, MSB first
    always_ff @(posedge clk) begin
        if (bus_busy && scl_rise && !last_bit) begin
            shift_q <= {shift_q[6:0], sda_s};
        end
        if (bus_busy && last_bit && !start_evt) begin
            slot_byte <= shift_q;
            // low SDA on the ninth bit means ack
            slot_ack  <= ~sda_s;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_line_sampler.sv
// samples the raw lines only, no glitch filter past the two sync flops; pulses lag the pins by 3
`timescale 1ns/100ps
`default_nettype none

module i2c_line_sampler (
    input  logic clk,
    input  logic rst_n,
    input  logic sda,
    input  logic scl,
    output logic sda_s,
    output logic start_evt,
    output logic stop_evt,
    output logic scl_rise
);

    // first synchronizer stage
    logic sda_meta;
    logic scl_meta;

    // second stage, the synchronized levels
    logic scl_s;

    // one cycle of history behind the synchronized levels
    logic sda_prev;
    logic scl_prev;

    // sync chain comes out of reset at the idle bus level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sda_meta <= 1'b1;
            scl_meta <= 1'b1;
            sda_s    <= 1'b1;
            scl_s    <= 1'b1;
            sda_prev <= 1'b1;
            scl_prev <= 1'b1;
        end else begin
            sda_meta <= sda;
            scl_meta <= scl;
            sda_s    <= sda_meta;
            scl_s    <= scl_meta;
            sda_prev <= sda_s;
            scl_prev <= scl_s;
        end
    end

    // registered condition pulses, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_evt <= 1'b0;
            stop_evt  <= 1'b0;
            scl_rise  <= 1'b0;
        end else begin
            // SDA falls while SCL stays high
            start_evt <= scl_s & scl_prev & sda_prev & ~sda_s;
            // SDA rises while SCL stays high
            stop_evt  <= scl_s & scl_prev & ~sda_prev & sda_s;
            scl_rise  <= scl_s & ~scl_prev;
        end
    end

endmodule

`default_nettype wire

//--- logic/i2c_mon_pkg.sv
// shared monitor types; record layout is fixed at 13 bits and the FIFO depth must stay at least 2
`default_nettype none

package i2c_mon_pkg;

    // record kinds as emitted on the output stream
    typedef enum logic [1:0] {
        REC_ADDR = 2'd0,
        REC_DATA = 2'd1,
        REC_STOP = 2'd2
    } rec_kind_t;

    // one event record, 13 bits wide
    typedef struct packed {
        // which bus event this record describes
        rec_kind_t  kind;
        // shifted byte, zero for a STOP record
        logic [7:0] byte_val;
        // SDA was low on the ninth SCL rise
        logic       ack;
        // address slot of a frame opened by a repeated START
        logic       restart;
        // STOP seen with a partial byte slot
        logic       err;
    } mon_rec_t;

    // transfer phase of the control FSM
    typedef enum logic [1:0] {
        MON_IDLE = 2'd0,
        MON_ADDR = 2'd1,
        MON_DATA = 2'd2
    } mon_state_t;

    // records held by the output FIFO
    localparam int unsigned REC_FIFO_DEPTH = 4;

    // FIFO pointer and occupancy widths
    localparam int unsigned REC_PTR_W = $clog2(REC_FIFO_DEPTH);
    localparam int unsigned REC_CNT_W = $clog2(REC_FIFO_DEPTH + 1);

    // SCL rises per byte slot, 8 data bits and the ack bit
    localparam int unsigned SLOT_BITS = 9;

    // width of the slot bit counter
    localparam int unsigned SLOT_CNT_W = 4;

endpackage

`default_nettype wire
